//--- project.f
+incdir+verilog
verilog/icache_pkg.sv
verilog/icache_sdp_ram.sv
verilog/icache_plru.sv
verilog/icache_refill.sv
verilog/icache_ctrl.sv
verilog/icache_top.sv
test/icache_mem_model.sv
test/icache_tb.sv

//--- test/icache_tb.sv
`include "icache_defines.svh"

module icache_tb;

    import icache_pkg::*;

    localparam int PAGE_W       = `ICACHE_INDEX_W + `ICACHE_OFFSET_W;
    localparam int SCRIPT_WORDS = 32;
    localparam int WATCH_CYCLES = SCRIPT_WORDS * 200 + 200;   // generous worst burst per word

    logic      clk;
    logic      rst;
    logic      inst_en;
    addr_t     inst_vaddr;
    tag_t      inst_pfn;
    logic      no_cache;
    addr_t     pc_next;
    logic      stall_f;
    cache_op_t cache_op;
    word_t     inst_rdata;
    logic      stall;
    rd_req_t   ar;
    logic      arvalid;
    logic      arready;
    word_t     rdata;
    logic      rvalid;
    logic      rlast;
    logic      rready;

    logic accept;
    int   err_count;
    int   pass_tests;
    int   fail_tests;
    int   req_count;     // address handshakes since the last accepted word

    // reference model of the tag side
    logic  m_valid [`ICACHE_WAYS][`ICACHE_SETS];
    tag_t  m_tag   [`ICACHE_WAYS][`ICACHE_SETS];
    plru_t m_lru   [`ICACHE_SETS];

    addr_t seq_addr [$];
    logic  seq_nc   [$];

    logic       exp_req;
    addr_t      exp_addr;
    logic [3:0] exp_len;
    way_t       exp_victim;

    icache_top u_dut (
        .clk, .rst, .inst_en, .inst_vaddr, .inst_pfn, .no_cache, .pc_next, .stall_f,
        .cache_op, .inst_rdata, .stall, .ar, .arvalid, .arready, .rdata, .rvalid,
        .rlast, .rready
    );

    icache_mem_model u_mem (
        .clk, .rst, .ar, .arvalid, .arready, .rdata, .rvalid, .rlast, .rready
    );

    always #10 clk = ~clk;

    assign accept = inst_en && !stall;

    always @(posedge clk) begin
        if (rst || accept) begin
            req_count <= 0;
        end else if (arvalid && arready) begin
            req_count <= req_count + 1;
        end
    end

    function automatic word_t scramble_word(input addr_t a);
        return a ^ {a[18:0], a[31:19]};
    endfunction

    function automatic set_idx_t set_of(input addr_t a);
        return a[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
    endfunction

    function automatic way_t victim_of(input plru_t t);
        return {t[0], t[0] ? t[2] : t[1]};  // root picks the half
    endfunction

    function automatic plru_t touch_way(input plru_t t, input way_t w);
        plru_t n;
        n    = t;
        n[0] = ~w[1];
        if (w[1]) begin
            n[2] = ~w[0];
        end else begin
            n[1] = ~w[0];
        end
        return n;
    endfunction

    task automatic lookup(input addr_t a, output logic found, output way_t way);
        found = 1'b0;
        way   = '0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (m_valid[w][set_of(a)] && m_tag[w][set_of(a)] == a[31:PAGE_W]) begin
                found = 1'b1;
                way   = way_t'(w);
            end
        end
    endtask

    task automatic compute_expect(input addr_t a, input logic nc);
        logic found;
        way_t w;
        lookup(a, found, w);
        exp_req    = nc || !found;
        exp_addr   = nc ? a : {a[31:`ICACHE_OFFSET_W], {`ICACHE_OFFSET_W{1'b0}}};
        exp_len    = nc ? 4'd0 : 4'(`ICACHE_LINE_WORDS - 1);
        exp_victim = victim_of(m_lru[set_of(a)]);
    endtask

    task automatic model_accept(input addr_t a, input logic nc);
        logic     found;
        way_t     w;
        set_idx_t s;
        s = set_of(a);
        lookup(a, found, w);
        if (!nc) begin
            if (!found) begin
                w            = victim_of(m_lru[s]);
                m_tag[w][s]  = a[31:PAGE_W];
                m_valid[w][s] = 1'b1;
            end
            m_lru[s] = touch_way(m_lru[s], w);
        end
    endtask

    task automatic add_fetch(input addr_t a, input logic nc);
        seq_addr.push_back(a);
        seq_nc.push_back(nc);
    endtask

    // fetch-stage driver running one scripted sequence
    task automatic run_seq(input string name);
        int    nxt;
        int    errs_before;
        addr_t cur;
        logic  cur_nc;
        errs_before = err_count;
        cur         = seq_addr[0];
        cur_nc      = seq_nc[0];
        @(posedge clk);
        inst_en    <= 1'b0;
        stall_f    <= 1'b0;
        inst_vaddr <= cur;
        inst_pfn   <= cur[31:PAGE_W];
        no_cache   <= cur_nc;
        pc_next    <= cur;
        compute_expect(cur, cur_nc);
        @(posedge clk);   // ram reads the first set
        @(posedge clk);
        inst_en <= 1'b1;
        pc_next <= (seq_addr.size() > 1) ? seq_addr[1] : cur;
        nxt = 1;
        forever begin
            @(posedge clk);
            if (accept) begin
                model_accept(cur, cur_nc);
                if (nxt < seq_addr.size()) begin
                    cur         = seq_addr[nxt];
                    cur_nc      = seq_nc[nxt];
                    inst_vaddr <= cur;
                    inst_pfn   <= cur[31:PAGE_W];
                    no_cache   <= cur_nc;
                    pc_next    <= (nxt + 1 < seq_addr.size()) ? seq_addr[nxt + 1] : cur;
                    compute_expect(cur, cur_nc);
                    nxt++;
                end else begin
                    inst_en <= 1'b0;
                    break;
                end
            end
        end
        seq_addr.delete();
        seq_nc.delete();
        if (err_count == errs_before) begin
            pass_tests++;
            $display("test %s: ok", name);
        end else begin
            fail_tests++;
            $display("test %s: %0d errors", name, err_count - errs_before);
        end
    endtask

    task automatic invalidate_line(input addr_t a);
        logic      found;
        way_t      w;
        cache_op_t op;
        lookup(a, found, w);
        if (!found) begin
            err_count++;
            $display("line %h to invalidate is not resident in the reference model", a);
        end
        op            = '0;
        op.invalidate = 1'b1;
        op.set        = set_of(a);
        op.way        = w;
        @(posedge clk);
        cache_op <= op;
        @(posedge clk);
        cache_op <= '0;
        m_valid[w][set_of(a)] = 1'b0;
    endtask

    a_reset_idle: assert property (@(posedge clk) $fell(rst) |-> !arvalid && !rready)
        else begin
            err_count++;
            $display("read channel not idle after reset at %0t", $time);
        end

    a_ar_hold: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(ar))
        else begin
            err_count++;
            $display("arvalid dropped or ar changed before arready at %0t", $time);
        end

    a_word: assert property (@(posedge clk) disable iff (rst)
        accept |-> inst_rdata == scramble_word({inst_pfn, inst_vaddr[PAGE_W-1:0]}))
        else begin
            err_count++;
            $display("[ERROR] %0t inst_rdata: got %h, expected %h", $time,
                     $sampled(inst_rdata),
                     scramble_word({$sampled(inst_pfn), $sampled(inst_vaddr[PAGE_W-1:0])}));
        end

    // a predicted hit is delivered without a stall cycle
    a_hit_stall: assert property (@(posedge clk) disable iff (rst)
        inst_en && !exp_req |-> !stall)
        else begin
            err_count++;
            $display("[ERROR] %0t stall: got %b, expected %b", $time,
                     $sampled(stall), 1'b0);
        end

    a_req_addr: assert property (@(posedge clk) disable iff (rst)
        arvalid && arready |-> ar.addr == exp_addr)
        else begin
            err_count++;
            $display("[ERROR] %0t ar.addr: got %h, expected %h", $time,
                     $sampled(ar.addr), $sampled(exp_addr));
        end

    a_req_len: assert property (@(posedge clk) disable iff (rst)
        arvalid && arready |-> ar.len == exp_len)
        else begin
            err_count++;
            $display("[ERROR] %0t ar.len: got %0d, expected %0d", $time,
                     $sampled(ar.len), $sampled(exp_len));
        end

    a_req_count: assert property (@(posedge clk) disable iff (rst)
        accept |-> req_count == int'(exp_req))
        else begin
            err_count++;
            $display("[ERROR] %0t req_count: got %0d, expected %0d for word %h", $time,
                     $sampled(req_count), int'($sampled(exp_req)), $sampled(inst_vaddr));
        end

    a_victim: assert property (@(posedge clk) disable iff (rst)
        u_dut.tag_we != '0 |-> u_dut.tag_we == way_mask_t'(1) << exp_victim)
        else begin
            err_count++;
            $display("[ERROR] %0t tag_we: got %b, expected way %0d", $time,
                     $sampled(u_dut.tag_we), $sampled(exp_victim));
        end

    initial begin
        #(WATCH_CYCLES * 20);
        $display("timeout: fetch script did not finish within %0d cycles", WATCH_CYCLES);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        inst_en    = 1'b0;
        inst_vaddr = '0;
        inst_pfn   = '0;
        no_cache   = 1'b0;
        pc_next    = '0;
        stall_f    = 1'b0;
        cache_op   = '0;
        err_count  = 0;
        pass_tests = 0;
        fail_tests = 0;
        for (int s = 0; s < `ICACHE_SETS; s++) begin
            m_lru[s] = '0;
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                m_valid[w][s] = 1'b0;
                m_tag[w][s]   = '0;
            end
        end

        repeat (16) @(posedge clk);
        rst <= 1'b0;

        // two lines back to back
        for (int i = 0; i < 12; i++) begin
            add_fetch(32'h0001_2000 + 4 * i, 1'b0);
        end
        run_seq("sequential refill");

        add_fetch(32'h0001_2000, 1'b0);
        add_fetch(32'h0001_2010, 1'b0);
        add_fetch(32'h0001_2024, 1'b0);
        add_fetch(32'h0001_201c, 1'b0);
        run_seq("refetch hits");

        add_fetch(32'h0004_0104, 1'b1);
        add_fetch(32'h0004_0108, 1'b1);
        add_fetch(32'h0004_0abc, 1'b1);
        run_seq("uncached");

        // five tags into set 5, then the four survivors and the evicted one
        for (int k = 0; k < 5; k++) begin
            add_fetch({20'h00100 + 20'(k), 7'd5, 5'h04}, 1'b0);
        end
        for (int k = 1; k < 5; k++) begin
            add_fetch({20'h00100 + 20'(k), 7'd5, 5'h08}, 1'b0);
        end
        add_fetch({20'h00100, 7'd5, 5'h0c}, 1'b0);
        run_seq("replacement");

        invalidate_line(32'h0001_2000);
        add_fetch(32'h0001_2000, 1'b0);
        add_fetch(32'h0001_2004, 1'b0);
        add_fetch(32'h0001_2024, 1'b0);
        run_seq("invalidate");

        repeat (4) @(posedge clk);
        $display("tests passed: %0d, failed: %0d, errors: %0d",
                 pass_tests, fail_tests, err_count);
        if (fail_tests == 0 && err_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- test/icache_mem_model.sv
`include "icache_defines.svh"

module icache_mem_model (
    input  logic                clk,
    input  logic                rst,
    input  icache_pkg::rd_req_t ar,
    input  logic                arvalid,
    output logic                arready,
    output icache_pkg::word_t   rdata,
    output logic                rvalid,
    output logic                rlast,
    input  logic                rready
);

    import icache_pkg::*;

    localparam logic [31:0] SEED = 32'd74093;

    logic [31:0] rnd_q;
    logic        busy_q;    // burst in progress
    addr_t       base_q;
    logic [3:0]  len_q;
    logic [3:0]  beat_q;    // beat currently on the bus
    logic [3:0]  cnt;

    // memory contents, a fixed scramble of the byte address
    function automatic word_t scramble_word(input addr_t a);
        return a ^ {a[18:0], a[31:19]};     // rotate left by 13
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    initial begin
        arready = 1'b0;
        rvalid  = 1'b0;
        rlast   = 1'b0;
        rdata   = '0;
        busy_q  = 1'b0;
        beat_q  = '0;
        rnd_q   = SEED;
    end

    always @(posedge clk) begin
        rnd_q = lcg_next(rnd_q);
        if (rst) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rlast   <= 1'b0;
            busy_q  <= 1'b0;
            beat_q  <= '0;
        end else if (!busy_q) begin
            rvalid <= 1'b0;
            if (arvalid && arready) begin
                busy_q  <= 1'b1;
                base_q  <= ar.addr;
                len_q   <= ar.len;
                beat_q  <= '0;
                arready <= 1'b0;
            end else begin
                arready <= rnd_q[29:28] != 2'b00;   // random address gaps
            end
        end else begin
            cnt = beat_q + 4'((rvalid && rready) ? 1 : 0);
            if (rvalid && rready && rlast) begin
                busy_q <= 1'b0;
                rvalid <= 1'b0;
                rlast  <= 1'b0;
            end else if (!rvalid || rready) begin
                beat_q <= cnt;
                rvalid <= rnd_q[30:28] != 3'b000;  // occasional data gap
                rdata  <= scramble_word(base_q + (addr_t'(cnt) << 2));
                rlast  <= (cnt == len_q);
            end
        end
    end

endmodule

//--- verilog/icache_top.sv
`include "icache_defines.svh"

module icache_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  inst_en,
    input  icache_pkg::addr_t     inst_vaddr,
    input  icache_pkg::tag_t      inst_pfn,
    input  logic                  no_cache,
    input  icache_pkg::addr_t     pc_next,
    input  logic                  stall_f,
    input  icache_pkg::cache_op_t cache_op,
    output icache_pkg::word_t     inst_rdata,
    output logic                  stall,
    output icache_pkg::rd_req_t   ar,
    output logic                  arvalid,
    input  logic                  arready,
    input  icache_pkg::word_t     rdata,
    input  logic                  rvalid,
    input  logic                  rlast,
    output logic                  rready
);

    import icache_pkg::*;

    localparam int LINE_W = `ICACHE_LINE_WORDS * $bits(word_t);

    logic                          ram_re;
    set_idx_t                      ram_raddr;
    set_idx_t                      wr_set;
    way_mask_t                     tag_we;
    way_mask_t                     victim_mask;
    logic                          start;
    logic                          uncached;
    logic                          done;
    logic                          lru_access;
    addr_t                         req_addr;
    word_sel_t                     req_word;
    word_sel_t                     word_off;
    way_t                          victim;
    way_t                          lru_way;
    word_t                         saved_word;
    word_t                         fill_data;
    logic [`ICACHE_LINE_WORDS-1:0] bank_we;
    tag_t  [`ICACHE_WAYS-1:0]      way_tags;
    word_t [`ICACHE_WAYS-1:0]      way_words;

    assign wr_set      = ar.addr[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];  // set of the open burst
    assign word_off    = inst_vaddr[`ICACHE_OFFSET_W-1:2];
    assign victim_mask = way_mask_t'(1) << victim;

    icache_ctrl u_ctrl (
        .clk, .rst, .inst_en, .inst_vaddr, .inst_pfn, .no_cache, .pc_next, .stall_f,
        .cache_op, .way_tags, .way_words, .victim, .done, .saved_word,
        .inst_rdata, .stall, .ram_re, .ram_raddr, .tag_we, .start, .uncached,
        .req_addr, .req_word, .lru_access, .lru_way
    );

    icache_plru u_plru (
        .clk, .rst,
        .set          (inst_vaddr[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W]),
        .access       (lru_access),
        .accessed_way (lru_way),
        .victim       (victim)
    );

    icache_refill u_refill (
        .clk, .rst, .start, .uncached, .req_addr, .req_word,
        .ar, .arvalid, .arready, .rdata, .rvalid, .rlast, .rready,
        .bank_we, .fill_data, .done, .saved_word
    );

    for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
        logic [LINE_W-1:0] line_rdata;

        icache_sdp_ram #(.WIDTH($bits(tag_t)), .DEPTH(`ICACHE_SETS)) u_tag_ram (
            .clk, .we(tag_we[w]), .waddr(wr_set), .wdata(ar.addr[31 -: `ICACHE_TAG_W]),
            .re(ram_re), .raddr(ram_raddr), .rdata(way_tags[w])
        );

        // whole line per row, one lane per word
        icache_sdp_ram #(
            .WIDTH (LINE_W),
            .DEPTH (`ICACHE_SETS),
            .LANES (`ICACHE_LINE_WORDS)
        ) u_data_ram (
            .clk,
            .we    (bank_we & {`ICACHE_LINE_WORDS{victim_mask[w]}}),
            .waddr (wr_set),
            .wdata ({`ICACHE_LINE_WORDS{fill_data}}),
            .re    (ram_re),
            .raddr (ram_raddr),
            .rdata (line_rdata)
        );

        assign way_words[w] = line_rdata[word_off*$bits(word_t) +: $bits(word_t)];
    end

endmodule

//--- verilog/icache_ctrl.sv
`include "icache_defines.svh"

module icache_ctrl (
    input  logic                                       clk,
    input  logic                                       rst,
    input  logic                                       inst_en,
    input  icache_pkg::addr_t                          inst_vaddr,
    input  icache_pkg::tag_t                           inst_pfn,
    input  logic                                       no_cache,
    input  icache_pkg::addr_t                          pc_next,
    input  logic                                       stall_f,
    input  icache_pkg::cache_op_t                      cache_op,
    input  icache_pkg::tag_t  [`ICACHE_WAYS-1:0]       way_tags,
    input  icache_pkg::word_t [`ICACHE_WAYS-1:0]       way_words,
    input  icache_pkg::way_t                           victim,
    input  logic                                       done,
    input  icache_pkg::word_t                          saved_word,
    output icache_pkg::word_t                          inst_rdata,
    output logic                                       stall,
    output logic                                       ram_re,
    output icache_pkg::set_idx_t                       ram_raddr,
    output icache_pkg::way_mask_t                      tag_we,
    output logic                                       start,
    output logic                                       uncached,
    output icache_pkg::addr_t                          req_addr,
    output icache_pkg::word_sel_t                      req_word,
    output logic                                       lru_access,
    output icache_pkg::way_t                           lru_way
);

    import icache_pkg::*;

    ctrl_state_t state_q;
    ctrl_state_t state_d;

    logic                    first_q;                    // first cycle out of reset
    logic [`ICACHE_SETS-1:0] valid_q [`ICACHE_WAYS];

    set_idx_t  index;
    set_idx_t  index_next;
    way_mask_t hit_mask;
    way_mask_t victim_mask;
    way_t      hit_way;
    logic      hit;
    logic      judge;
    logic      fill_end;   // last beat of a cached refill
    logic      hit_out;

    assign index      = inst_vaddr[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
    assign index_next = pc_next[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];

    assign judge    = (state_q == HIT_JUDGE);
    assign fill_end = done && (state_q == LOAD_LINE);

    // tag compare over the valid ways
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            hit_mask[w] = valid_q[w][index] && (way_tags[w] == inst_pfn);
            if (hit_mask[w]) begin
                hit_way = way_t'(w);
            end
        end
    end

    assign hit     = |hit_mask;
    assign hit_out = judge && hit && !no_cache;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (!stall_f) state_d = HIT_JUDGE;   // ram has read pc_next
            end
            HIT_JUDGE: begin
                if (inst_en && no_cache) begin
                    state_d = UNCACHED;
                end else if (inst_en && !hit) begin
                    state_d = LOAD_LINE;
                end
            end
            LOAD_LINE, UNCACHED: begin
                if (done) state_d = IDLE;
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= IDLE;
            first_q <= 1'b1;
        end else begin
            state_q <= state_d;
            first_q <= 1'b0;
        end
    end

    // valid bits, cache op wins over a fill on the same edge
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                valid_q[w] <= '0;
            end
        end else begin
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                if (tag_we[w]) valid_q[w][index] <= 1'b1;
            end
            if (cache_op.invalidate || cache_op.store_tag) begin
                valid_q[cache_op.way][cache_op.set] <= 1'b0;
            end
        end
    end

    assign stall      = inst_en && !(state_q == IDLE || hit_out);
    assign inst_rdata = hit_out ? way_words[hit_way] : saved_word;

    // pre-index with the next pc
    assign ram_re    = !stall_f;
    assign ram_raddr = first_q ? index : index_next;

    assign start    = judge && inst_en && (no_cache || !hit);
    assign uncached = no_cache;
    assign req_addr = {inst_pfn, inst_vaddr[`ICACHE_INDEX_W+`ICACHE_OFFSET_W-1:0]};
    assign req_word = inst_vaddr[`ICACHE_OFFSET_W-1:2];

    assign victim_mask = way_mask_t'(1) << victim;
    assign tag_we      = fill_end ? victim_mask : '0;

    assign lru_access = (hit_out && inst_en) || fill_end;
    assign lru_way    = judge ? hit_way : victim;

    // a second matching way means a refill landed on a resident line
    a_hit_onehot: assert property (@(posedge clk) disable iff (rst)
        judge |-> $onehot0(hit_mask))
        else $error("more than one way hit in set %0d", index);

endmodule

//--- verilog/icache_refill.sv
`include "icache_defines.svh"

module icache_refill (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          start,
    input  logic                          uncached,
    input  icache_pkg::addr_t             req_addr,
    input  icache_pkg::word_sel_t         req_word,
    output icache_pkg::rd_req_t           ar,
    output logic                          arvalid,
    input  logic                          arready,
    input  icache_pkg::word_t             rdata,
    input  logic                          rvalid,
    input  logic                          rlast,
    output logic                          rready,
    output logic [`ICACHE_LINE_WORDS-1:0] bank_we,
    output icache_pkg::word_t             fill_data,
    output logic                          done,
    output icache_pkg::word_t             saved_word
);

    import icache_pkg::*;

    logic      read_req_q;  // transaction open
    logic      addr_rcv_q;  // address handshake done
    logic      uncached_q;
    word_sel_t cnt_q;       // beat number
    word_sel_t req_word_q;
    rd_req_t   ar_q;
    word_t     saved_q;
    logic      beat;

    assign arvalid = read_req_q & ~addr_rcv_q;
    assign rready  = addr_rcv_q;
    assign ar      = ar_q;

    assign beat = rvalid & rready;
    assign done = beat & rlast;

    assign fill_data  = rdata;
    assign saved_word = saved_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            read_req_q <= 1'b0;
            addr_rcv_q <= 1'b0;
            uncached_q <= 1'b0;
            cnt_q      <= '0;
        end else begin
            if (start) begin
                read_req_q <= 1'b1;
                uncached_q <= uncached;
            end else if (done) begin
                read_req_q <= 1'b0;
            end

            if (arvalid && arready) begin
                addr_rcv_q <= 1'b1;
            end else if (done) begin
                addr_rcv_q <= 1'b0;
            end

            if (done) begin
                cnt_q <= '0;
            end else if (beat) begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    // request payload latched once so ar stays put while waiting
    always_ff @(posedge clk) begin
        if (start) begin
            ar_q.addr  <= uncached ? req_addr
                                   : {req_addr[31:`ICACHE_OFFSET_W], {`ICACHE_OFFSET_W{1'b0}}};
            ar_q.len   <= uncached ? 4'd0 : 4'(`ICACHE_LINE_WORDS - 1);
            req_word_q <= req_word;
        end
        if (beat && (uncached_q || cnt_q == req_word_q)) begin
            saved_q <= rdata;   // the word the fetch stage waits for
        end
    end

    // one word strobe per beat, cached fills only
    always_comb begin
        bank_we = '0;
        if (beat && !uncached_q) begin
            bank_we[cnt_q] = 1'b1;
        end
    end

    property p_ar_held;
        @(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(ar);
    endproperty

    a_ar_held: assert property (p_ar_held)
        else $error("arvalid dropped or ar changed before arready");

endmodule

//--- verilog/icache_plru.sv
`include "icache_defines.svh"

module icache_plru (
    input  logic                 clk,
    input  logic                 rst,
    input  icache_pkg::set_idx_t set,
    input  logic                 access,
    input  icache_pkg::way_t     accessed_way,
    output icache_pkg::way_t     victim
);

    import icache_pkg::*;

    // bit 0 root, bit 1 leaf over ways 0/1, bit 2 leaf over ways 2/3
    plru_t tree_q [`ICACHE_SETS];
    plru_t cur;

    // point every node on the path away from the touched way
    function automatic plru_t touch(plru_t bits, way_t way);
        plru_t nxt;
        nxt    = bits;
        nxt[0] = ~way[1];           // root to the other half
        if (way[1]) begin
            nxt[2] = ~way[0];
        end else begin
            nxt[1] = ~way[0];
        end
        return nxt;
    endfunction

    assign cur = tree_q[set];

    // root picks the half, that half's leaf picks the way
    assign victim = {cur[0], cur[0] ? cur[2] : cur[1]};

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < `ICACHE_SETS; s++) begin
                tree_q[s] <= '0;
            end
        end else if (access) begin
            tree_q[set] <= touch(cur, accessed_way);
        end
    end

endmodule

//--- verilog/icache_sdp_ram.sv
module icache_sdp_ram #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 128,
    parameter int LANES = 1     // independently writable slices of a row
) (
    input  logic                   clk,
    input  logic [LANES-1:0]       we,
    input  icache_pkg::set_idx_t   waddr,
    input  logic [WIDTH-1:0]       wdata,
    input  logic                   re,
    input  icache_pkg::set_idx_t   raddr,
    output logic [WIDTH-1:0]       rdata
);

    localparam int LANE_W = WIDTH / LANES;

    logic [WIDTH-1:0] mem [DEPTH];

    // write port, one enable per lane
    always_ff @(posedge clk) begin
        for (int l = 0; l < LANES; l++) begin
            if (we[l]) begin
                mem[waddr][l*LANE_W +: LANE_W] <= wdata[l*LANE_W +: LANE_W];
            end
        end
    end

    // registered read, old data on a same-address write
    always_ff @(posedge clk) begin
        if (re) begin
            rdata <= mem[raddr];
        end
    end

endmodule

//--- verilog/icache_pkg.sv
`include "icache_defines.svh"

package icache_pkg;

    typedef logic [31:0] word_t;   // instruction / bus data
    typedef logic [31:0] addr_t;   // bus or virtual address

    typedef logic [`ICACHE_TAG_W-1:0]   tag_t;
    typedef logic [`ICACHE_INDEX_W-1:0] set_idx_t;

    typedef logic [$clog2(`ICACHE_LINE_WORDS)-1:0] word_sel_t;  // word in line, also beat no.
    typedef logic [$clog2(`ICACHE_WAYS)-1:0]       way_t;
    typedef logic [`ICACHE_WAYS-1:0]               way_mask_t;
    typedef logic [`ICACHE_WAYS-2:0]               plru_t;      // tree bits of one set

    // cache instruction from the memory stage
    typedef struct packed {
        logic     invalidate;   // index-invalidate
        logic     store_tag;    // index-store-tag
        set_idx_t set;
        way_t     way;
    } cache_op_t;

    // read address channel payload
    typedef struct packed {
        addr_t      addr;
        logic [3:0] len;        // beats minus one
    } rd_req_t;

    typedef enum logic [1:0] {
        IDLE,
        HIT_JUDGE,
        LOAD_LINE,
        UNCACHED
    } ctrl_state_t;

endpackage

//--- verilog/icache_defines.svh
`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

// physical frame number width, taken straight from the TLB
`define ICACHE_TAG_W 20

// 128 sets
`define ICACHE_INDEX_W 7

// byte offset within a 32-byte line
`define ICACHE_OFFSET_W 5

// associativity
`define ICACHE_WAYS 4

// words per line, also the burst length of a refill
`define ICACHE_LINE_WORDS 8

// derived
`define ICACHE_SETS (1 << `ICACHE_INDEX_W)

`endif
